// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_calc -o tb_calc

# The simulator exits non-zero on failure, the log decides the verdict
./obj_dir/tb_calc > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0

// File: tb/calc_stimulus.txt
# button(U D L R C) mode(1 hex, 0 dec) then expected after the press:
# col row state(0 op1, 1 op2, 2 result) display(hex)
L 0 0 0 0 0000
U 0 0 0 0 0000
R 0 1 0 0 0000
C 0 1 0 0 0001
R 0 2 0 0 0001
C 0 2 0 0 000c
R 0 3 0 0 000c
D 0 3 1 0 000c
D 0 3 2 0 000c
C 0 3 2 0 000c
R 0 4 2 0 000c
R 0 5 2 0 000c
R 0 5 2 0 000c
D 0 5 3 0 000c
D 0 5 3 0 000c
C 0 5 3 0 0000
U 1 5 2 0 0000
U 1 5 1 0 0000
U 1 5 0 0 0000
L 1 4 0 0 0000
L 1 3 0 0 0000
C 1 3 0 0 0003
D 1 3 1 0 0003
D 1 3 2 0 0003
L 1 2 2 0 0003
C 1 2 2 0 003a
R 1 3 2 0 003a
R 1 4 2 0 003a
U 1 4 1 0 003a
U 1 4 0 0 003a
C 1 4 0 1 0000
L 1 3 0 1 0000
L 1 2 0 1 0000
L 1 1 0 1 0000
C 1 1 0 1 0001
R 1 2 0 1 0001
C 1 2 0 1 0012
R 1 3 0 1 0012
R 1 4 0 1 0012
D 1 4 1 1 0012
D 1 4 2 1 0012
D 1 4 3 1 0012
C 1 4 3 2 004c
R 1 5 3 2 004c
U 1 5 2 2 004c
U 1 5 1 2 004c
U 1 5 0 2 004c
C 1 5 0 1 0000
L 1 4 0 1 0000
L 1 3 0 1 0000
C 1 3 0 1 0003
C 1 3 0 1 0033
C 1 3 0 1 0333
R 1 4 0 1 0333
D 1 4 1 1 0333
D 1 4 2 1 0333
D 1 4 3 1 0333
C 1 4 3 2 fd19
U 1 4 2 2 fd19
U 1 4 1 2 fd19
C 1 4 1 1 0000
L 1 3 1 1 0000
C 1 3 1 1 0007
R 1 4 1 1 0007
D 1 4 2 1 0007
D 1 4 3 1 0007
C 1 4 3 2 ebaf
U 1 4 2 2 ebaf
C 1 4 2 1 0000
L 1 3 2 1 0000
C 1 3 2 1 000b
C 1 3 2 1 00bb
R 1 4 2 1 00bb
R 1 5 2 1 00bb
C 1 5 2 1 0000
L 1 4 2 1 0000
L 1 3 2 1 0000
C 1 3 2 1 000b
R 1 4 2 1 000b
D 1 4 3 1 000b
C 1 4 3 2 000b
R 1 5 3 2 000b
U 1 5 2 2 000b
U 1 5 1 2 000b
C 1 5 1 1 0000
L 1 4 1 1 0000
L 1 3 1 1 0000
C 1 3 1 1 0007
R 1 4 1 1 0007
D 1 4 2 1 0007
D 1 4 3 1 0007
C 1 4 3 2 000f

// File: tb/calc_checks.svh
`ifndef CALC_CHECKS_SVH
`define CALC_CHECKS_SVH

int error_count = 0;

// Ends the run on the first error
task automatic stop_run();
	$display("Simulation FAILED");
	$fatal(1, "Run stopped at first error");
endtask

task automatic check_display(input operand_t expected, input operand_t actual);
	if (actual !== expected) begin
		$display("FAILED at %0t ns: display expected %h, got %h", $time, expected, actual);
		error_count++;
		stop_run();
	end
endtask

task automatic check_state(input calc_state_e expected, input calc_state_e actual);
	if (actual !== expected) begin
		$display("FAILED at %0t ns: state expected %s, got %s",
			$time, expected.name(), actual.name());
		error_count++;
		stop_run();
	end
endtask

// Column and row are reported separately
task automatic check_cursor(input col_t exp_col, input row_t exp_row,
		input col_t act_col, input row_t act_row);
	if (act_col !== exp_col) begin
		$display("FAILED at %0t ns: cursor_col expected %0d, got %0d",
			$time, exp_col, act_col);
		error_count++;
		stop_run();
	end
	if (act_row !== exp_row) begin
		$display("FAILED at %0t ns: cursor_row expected %0d, got %0d",
			$time, exp_row, act_row);
		error_count++;
		stop_run();
	end
endtask

`endif

// File: tb/tb_calc.sv
`timescale 1ns/1ps

module tb_calc
	import calc_pkg::*;
	import keypad_pkg::*;
();

	localparam int CLK_PERIOD  = 10;
	localparam int HOLD_CYCLES = 14;
	localparam int GAP_CYCLES  = 4;
	localparam int unsigned SEED = 32'hab44;

	logic        clk = 1'b0;
	logic        rst;
	logic        mode;
	logic        btn_up;
	logic        btn_down;
	logic        btn_left;
	logic        btn_right;
	logic        btn_center;
	operand_t    display;
	calc_state_e state;
	col_t        cursor_col;
	row_t        cursor_row;

	// One entry per stimulus line
	byte         btn_q[$];
	logic        mode_q[$];
	col_t        col_q[$];
	row_t        row_q[$];
	calc_state_e state_q[$];
	operand_t    disp_q[$];

	int unsigned timeout_limit = 0;
	int unsigned cycle_count = 0;

	`include "calc_checks.svh"

	calc_top #(.DEBOUNCE_CYCLES(8)) u_dut (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.btn_up    (btn_up),
		.btn_down  (btn_down),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_center(btn_center),
		.display   (display),
		.state     (state),
		.cursor_col(cursor_col),
		.cursor_row(cursor_row)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			$display("Run timed out after %0d cycles", cycle_count);
			stop_run();
		end
	end

	task automatic load_stimulus();
		int       fd;
		string    line;
		byte      code;
		int       m;
		int       c;
		int       r;
		int       s;
		logic [15:0] d;
		int       n;
		fd = $fopen("tb/calc_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/calc_stimulus.txt");
			stop_run();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip blank and comment lines
			if (line.len() < 2 || line[0] == "#") continue;
			n = $sscanf(line, "%c %d %d %d %d %h", code, m, c, r, s, d);
			if (n != 6) begin
				$display("Malformed stimulus line: %s", line);
				stop_run();
			end
			btn_q.push_back(code);
			mode_q.push_back(m[0]);
			col_q.push_back(col_t'(c));
			row_q.push_back(row_t'(r));
			state_q.push_back(calc_state_e'(s));
			disp_q.push_back(operand_t'(d));
		end
		$fclose(fd);
	endtask

	task automatic drive_button(input byte code, input logic level);
		case (code)
			"U": btn_up <= level;
			"D": btn_down <= level;
			"L": btn_left <= level;
			"R": btn_right <= level;
			"C": btn_center <= level;
			default: begin
				$display("Unknown button code %c in the stimulus file", code);
				stop_run();
			end
		endcase
	endtask

	// Random pause, then hold the button long enough to pass the debouncer
	task automatic apply_press(input byte code, input logic m);
		int pause;
		pause = $urandom % 4;
		repeat (pause) @(posedge clk);
		@(posedge clk);
		mode <= m;
		drive_button(code, 1'b1);
		repeat (HOLD_CYCLES) @(posedge clk);
		drive_button(code, 1'b0);
		repeat (GAP_CYCLES) @(posedge clk);
	endtask

	initial begin
		rst        = 1'b1;
		mode       = 1'b0;
		btn_up     = 1'b0;
		btn_down   = 1'b0;
		btn_left   = 1'b0;
		btn_right  = 1'b0;
		btn_center = 1'b0;
		void'($urandom(SEED));
		load_stimulus();
		timeout_limit = btn_q.size() * (HOLD_CYCLES + GAP_CYCLES + 3) * 2;

		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Reset values
		@(negedge clk);
		check_cursor('0, '0, cursor_col, cursor_row);
		check_state(ST_OP1, state);
		check_display('0, display);

		for (int i = 0; i < btn_q.size(); i++) begin
			apply_press(btn_q[i], mode_q[i]);
			@(negedge clk);
			check_cursor(col_q[i], row_q[i], cursor_col, cursor_row);
			check_state(state_q[i], state);
			check_display(disp_q[i], display);
		end

		if (error_count == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// File: verilog.f
verilog/calc_pkg.sv
verilog/keypad_pkg.sv
verilog/button_debouncer.sv
verilog/grid_cursor.sv
verilog/calc_alu.sv
verilog/calc_entry.sv
verilog/calc_top.sv
+incdir+tb
tb/tb_calc.sv

// File: verilog/button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer #(
	parameter int unsigned DEBOUNCE_CYCLES = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic button,
	output logic press
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
	// Count value on the edge that fires the pulse
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DEBOUNCE_CYCLES - 1);
	// Saturated count, held until release
	localparam logic [CNT_W-1:0] DONE = CNT_W'(DEBOUNCE_CYCLES);

	logic             sync_meta;
	logic             sync_level;
	logic [CNT_W-1:0] stable_cnt;

	// Two flop synchroniser
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sync_meta  <= 1'b0;
			sync_level <= 1'b0;
		end else begin
			sync_meta  <= button;
			sync_level <= sync_meta;
		end
	end

	// Any low sample restarts the count and re-arms the pulse
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stable_cnt <= '0;
			press      <= 1'b0;
		end else if (!sync_level) begin
			stable_cnt <= '0;
			press      <= 1'b0;
		end else begin
			press <= (stable_cnt == LAST);
			if (stable_cnt != DONE) begin
				stable_cnt <= stable_cnt + CNT_W'(1);
			end
		end
	end

endmodule

// File: verilog/calc_alu.sv
`timescale 1ns/1ps

module calc_alu
	import calc_pkg::*;
(
	input  operand_t op_a,
	input  operand_t op_b,
	input  opcode_e  opcode,
	output operand_t alu_result
);

	// All results keep the low 16 bits, so subtraction wraps
	always_comb begin
		case (opcode)
			OP_ADD:  alu_result = op_a + op_b;
			OP_SUB:  alu_result = op_a - op_b;
			OP_MUL:  alu_result = operand_t'(op_a * op_b);
			OP_AND:  alu_result = op_a & op_b;
			OP_OR:   alu_result = op_a | op_b;
			default: alu_result = '0;
		endcase
	end

endmodule

// File: verilog/calc_entry.sv
`timescale 1ns/1ps

module calc_entry
	import calc_pkg::*;
	import keypad_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        mode,
	input  logic        select_press,
	input  key_e        key,
	input  operand_t    alu_result,
	output operand_t    op_a,
	output operand_t    op_b,
	output opcode_e     opcode,
	output calc_state_e state,
	output operand_t    display
);

	operand_t    result;
	logic [3:0]  digit;
	logic        is_digit;
	logic        digit_ok;
	logic        is_operator;

	// Append one digit in the current radix, wrapping at 16 bits
	function automatic operand_t shift_in(operand_t cur, logic [3:0] d, logic hex);
		operand_t scaled;
		if (hex) begin
			scaled = {cur[11:0], 4'h0};
		end else begin
			scaled = operand_t'(cur * 16'd10);
		end
		return scaled + operand_t'(d);
	endfunction

	// Operator key to ALU opcode
	function automatic opcode_e op_of(key_e k);
		opcode_e op;
		case (k)
			KEY_SUB: op = OP_SUB;
			KEY_MUL: op = OP_MUL;
			KEY_AND: op = OP_AND;
			KEY_OR:  op = OP_OR;
			default: op = OP_ADD;
		endcase
		return op;
	endfunction

	assign digit       = key[3:0];
	assign is_digit    = (key <= KEY_F);
	// A to F only count in hex mode
	assign digit_ok    = is_digit && (mode || key <= KEY_9);
	assign is_operator = key inside {KEY_ADD, KEY_SUB, KEY_MUL, KEY_OR, KEY_AND};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state  <= ST_OP1;
			op_a   <= '0;
			op_b   <= '0;
			opcode <= OP_ADD;
			result <= '0;
		end else if (select_press) begin
			if (key == KEY_CLR) begin
				state  <= ST_OP1;
				op_a   <= '0;
				op_b   <= '0;
				opcode <= OP_ADD;
				result <= '0;
			end else if (key == KEY_CE) begin
				// Only the operand being typed
				if (state == ST_OP1) begin
					op_a <= '0;
				end else if (state == ST_OP2) begin
					op_b <= '0;
				end
			end else if (is_digit) begin
				if (digit_ok) begin
					case (state)
						ST_OP1: op_a <= shift_in(op_a, digit, mode);
						ST_OP2: op_b <= shift_in(op_b, digit, mode);
						ST_RESULT: begin
							// New digit starts a fresh calculation
							op_a  <= operand_t'(digit);
							state <= ST_OP1;
						end
						default: state <= ST_OP1;
					endcase
				end
			end else if (is_operator) begin
				if (state == ST_OP1 || state == ST_RESULT) begin
					// Chained operation reuses the last result
					if (state == ST_RESULT) begin
						op_a <= result;
					end
					opcode <= op_of(key);
					op_b   <= '0;
					state  <= ST_OP2;
				end
			end else if (key == KEY_EXE && state == ST_OP2) begin
				result <= alu_result;
				state  <= ST_RESULT;
			end
		end
	end

	// Value shown follows the entry state
	always_comb begin
		case (state)
			ST_OP1:    display = op_a;
			ST_OP2:    display = op_b;
			ST_RESULT: display = result;
			default:   display = '0;
		endcase
	end

endmodule

// File: verilog/calc_pkg.sv
package calc_pkg;

	// One operand, the result, or the value on the display
	typedef logic [15:0] operand_t;

	// ALU operation codes
	typedef enum logic [3:0] {
		OP_ADD = 4'b0000,
		OP_MUL = 4'b0001,
		OP_AND = 4'b0010,
		OP_SUB = 4'b0100,
		OP_OR  = 4'b0101
	} opcode_e;

	// Entry progress of the calculator
	typedef enum logic [1:0] {
		// Typing the first operand
		ST_OP1,
		// Operator chosen, typing the second operand
		ST_OP2,
		// Result shown until the next key
		ST_RESULT
	} calc_state_e;

endpackage

// File: verilog/calc_top.sv
`timescale 1ns/1ps

module calc_top
	import calc_pkg::*;
	import keypad_pkg::*;
#(
	parameter int unsigned DEBOUNCE_CYCLES = 8
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        mode,
	input  logic        btn_up,
	input  logic        btn_down,
	input  logic        btn_left,
	input  logic        btn_right,
	input  logic        btn_center,
	output operand_t    display,
	output calc_state_e state,
	output col_t        cursor_col,
	output row_t        cursor_row
);

	logic     up_press;
	logic     down_press;
	logic     left_press;
	logic     right_press;
	logic     select_press;
	key_e     key;
	operand_t op_a;
	operand_t op_b;
	opcode_e  opcode;
	operand_t alu_result;

	// One debouncer per push button
	button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_up (
		.clk(clk), .rst(rst), .button(btn_up), .press(up_press)
	);
	button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_down (
		.clk(clk), .rst(rst), .button(btn_down), .press(down_press)
	);
	button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_left (
		.clk(clk), .rst(rst), .button(btn_left), .press(left_press)
	);
	button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_right (
		.clk(clk), .rst(rst), .button(btn_right), .press(right_press)
	);
	button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_deb_center (
		.clk(clk), .rst(rst), .button(btn_center), .press(select_press)
	);

	grid_cursor u_cursor (
		.clk        (clk),
		.rst        (rst),
		.up_press   (up_press),
		.down_press (down_press),
		.left_press (left_press),
		.right_press(right_press),
		.cursor_col (cursor_col),
		.cursor_row (cursor_row),
		.key        (key)
	);

	calc_entry u_entry (
		.clk         (clk),
		.rst         (rst),
		.mode        (mode),
		.select_press(select_press),
		.key         (key),
		.alu_result  (alu_result),
		.op_a        (op_a),
		.op_b        (op_b),
		.opcode      (opcode),
		.state       (state),
		.display     (display)
	);

	calc_alu u_alu (
		.op_a      (op_a),
		.op_b      (op_b),
		.opcode    (opcode),
		.alu_result(alu_result)
	);

endmodule

// File: verilog/grid_cursor.sv
`timescale 1ns/1ps

module grid_cursor
	import keypad_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic up_press,
	input  logic down_press,
	input  logic left_press,
	input  logic right_press,
	output col_t cursor_col,
	output row_t cursor_row,
	output key_e key
);

	localparam col_t LAST_COL = col_t'(GRID_COLS - 1);
	localparam row_t LAST_ROW = row_t'(GRID_ROWS - 1);

	logic at_top;
	logic at_bottom;
	logic at_left;
	logic at_right;

	assign at_top    = (cursor_row == '0);
	assign at_bottom = (cursor_row == LAST_ROW);
	assign at_left   = (cursor_col == '0);
	assign at_right  = (cursor_col == LAST_COL);

	// Row moves, clamped at the top and bottom edges
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cursor_row <= '0;
		end else if (up_press && !at_top) begin
			cursor_row <= cursor_row - row_t'(1);
		end else if (down_press && !at_bottom) begin
			cursor_row <= cursor_row + row_t'(1);
		end
	end

	// Column moves, clamped at the left and right edges
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cursor_col <= '0;
		end else if (left_press && !at_left) begin
			cursor_col <= cursor_col - col_t'(1);
		end else if (right_press && !at_right) begin
			cursor_col <= cursor_col + col_t'(1);
		end
	end

	// Key under the cursor tracks the registered position
	assign key = key_at(cursor_col, cursor_row);

endmodule

// File: verilog/keypad_pkg.sv
package keypad_pkg;

	// Key grid size
	localparam int GRID_COLS = 6;
	localparam int GRID_ROWS = 4;

	typedef logic [2:0] col_t;
	typedef logic [1:0] row_t;

	// Digit keys carry their own value
	typedef enum logic [4:0] {
		KEY_0, KEY_1, KEY_2, KEY_3,
		KEY_4, KEY_5, KEY_6, KEY_7,
		KEY_8, KEY_9, KEY_A, KEY_B,
		KEY_C, KEY_D, KEY_E, KEY_F,
		KEY_ADD,
		KEY_SUB,
		KEY_MUL,
		KEY_OR,
		KEY_AND,
		KEY_CE,
		KEY_EXE,
		KEY_CLR
	} key_e;

	// Key printed on the grid cell at (col, row)
	function automatic key_e key_at(col_t col, row_t row);
		key_e k;
		if (col < 3'd4) begin
			// Digits fill the left block row by row
			k = key_e'({1'b0, row, col[1:0]});
		end else if (col == 3'd4) begin
			case (row)
				2'd0: k = KEY_ADD;
				2'd1: k = KEY_MUL;
				2'd2: k = KEY_AND;
				default: k = KEY_EXE;
			endcase
		end else begin
			case (row)
				2'd0: k = KEY_SUB;
				2'd1: k = KEY_OR;
				2'd2: k = KEY_CE;
				default: k = KEY_CLR;
			endcase
		end
		return k;
	endfunction

endpackage
